// File: rtl/colorbin_pkg.sv
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colorbin package: class codes, counter and pixel widths, HSV
// thresholds and the packed face word shared by the colour binner
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package colorbin_pkg;

	// NONE only appears on the face output after reset
	typedef enum logic [2:0] {
		NONE   = 3'd0,
		RED    = 3'd1,
		ORANGE = 3'd2,
		YELLOW = 3'd3,
		GREEN  = 3'd4,
		BLUE   = 3'd5,
		WHITE  = 3'd6,
		OTHER  = 3'd7
	} color_e;

	localparam int NUM_CLASSES = 7;
	// row-major, index = row*3 + col
	localparam int NUM_CELLS   = 9;

	typedef logic [3:0] cell_idx_t;

	localparam int COUNT_W = 15;
	typedef logic [COUNT_W-1:0] count_t;

	// hsv inputs, only the top FIELD_W bits carry the integer part
	localparam int PIX_W   = 16;
	localparam int FIELD_W = 10;

	localparam logic [FIELD_W-1:0] SAT_WHITE_MAX  = 10'd10;
	localparam logic [FIELD_W-1:0] SAT_MIN        = 10'd50;
	localparam logic [FIELD_W-1:0] ORANGE_SAT_MIN = 10'd90;
	localparam logic [FIELD_W-1:0] VALUE_MIN      = 10'd10;

	// hue in degrees
	localparam logic [FIELD_W-1:0] HUE_RED_LO    = 10'd325;
	localparam logic [FIELD_W-1:0] HUE_ORANGE_LO = 10'd10;
	localparam logic [FIELD_W-1:0] HUE_YELLOW_LO = 10'd40;
	localparam logic [FIELD_W-1:0] HUE_GREEN_LO  = 10'd75;
	localparam logic [FIELD_W-1:0] HUE_BLUE_LO   = 10'd140;
	localparam logic [FIELD_W-1:0] HUE_BLUE_HI   = 10'd280;

	// cell n at bits 3n+2:3n
	typedef color_e [NUM_CELLS-1:0] face_t;

endpackage

`default_nettype wire

// File: rtl/pixel_tag_if.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pixel tag: one registered pixel with its cell position and class,
// passed from the locator and classifier to the histogram
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface pixel_tag_if;

	logic                    tag_valid;
	// pixel inside one of the nine cells
	logic                    tag_hit;
	colorbin_pkg::cell_idx_t tag_cell;
	// last pixel of the frame
	logic                    tag_last;
	colorbin_pkg::color_e    tag_class;

	modport locator (
		output tag_valid,
		output tag_hit,
		output tag_cell,
		output tag_last
	);

	modport classifier (
		output tag_class
	);

	modport sink (
		input tag_valid,
		input tag_hit,
		input tag_cell,
		input tag_last,
		input tag_class
	);

endinterface

`default_nettype wire

// File: rtl/grid_locator.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// grid locator: raster x/y counters, 3x3 cell window lookup and the
// end-of-frame mark, registered as the pixel tag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module grid_locator #(
	parameter int FRAME_W    = 480,
	parameter int FRAME_H    = 480,
	parameter int CELL_SIZE  = 156,
	parameter int CELL_PITCH = 160
) (
	input  wire         i_clk,
	input  wire         i_rstn,
	input  wire         i_valid,
	pixel_tag_if.locator o_tag
);

	localparam int X_W = $clog2(FRAME_W);
	localparam int Y_W = $clog2(FRAME_H);

	logic [X_W-1:0] pos_x;
	logic [Y_W-1:0] pos_y;
	logic [2:0]     col_win;
	logic [2:0]     row_win;
	logic           at_last;

	// {hit, index} of the window holding pos, window n starts at n*pitch
	function automatic logic [2:0] win_lookup(input int unsigned pos);
		logic [2:0] res;
		res = 3'b000;
		for (int n = 0; n < 3; n++) begin
			if (pos >= n * CELL_PITCH && pos < n * CELL_PITCH + CELL_SIZE) begin
				res = {1'b1, 2'(n)};
			end
		end
		return res;
	endfunction

	assign col_win = win_lookup(pos_x);
	assign row_win = win_lookup(pos_y);
	assign at_last = (pos_x == X_W'(FRAME_W - 1)) && (pos_y == Y_W'(FRAME_H - 1));

	// raster position, stalls while i_valid is low
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			pos_x <= '0;
			pos_y <= '0;
		end else if (i_valid) begin
			if (pos_x == X_W'(FRAME_W - 1)) begin
				pos_x <= '0;
				pos_y <= (pos_y == Y_W'(FRAME_H - 1)) ? '0 : pos_y + 1'b1;
			end else begin
				pos_x <= pos_x + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			o_tag.tag_valid <= 1'b0;
		end else begin
			o_tag.tag_valid <= i_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			o_tag.tag_hit  <= col_win[2] & row_win[2];
			o_tag.tag_cell <= {2'b00, row_win[1:0]} * 4'd3 + {2'b00, col_win[1:0]};
			o_tag.tag_last <= at_last;
		end
	end

endmodule

`default_nettype wire

// File: rtl/hsv_classify.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hsv classifier: maps one HSV pixel to a colour class code with an
// ordered set of threshold rules, registered alongside the locator tag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module hsv_classify (
	input  wire                            i_clk,
	input  wire [colorbin_pkg::PIX_W-1:0] i_hue,
	input  wire [colorbin_pkg::PIX_W-1:0] i_sat,
	input  wire [colorbin_pkg::PIX_W-1:0] i_value,
	input  wire                            i_valid,
	pixel_tag_if.classifier                o_tag
);

	logic [colorbin_pkg::FIELD_W-1:0] hue;
	logic [colorbin_pkg::FIELD_W-1:0] sat;
	logic [colorbin_pkg::FIELD_W-1:0] val;
	colorbin_pkg::color_e             cls;

	// integer parts only
	assign hue = i_hue[colorbin_pkg::PIX_W-1 -: colorbin_pkg::FIELD_W];
	assign sat = i_sat[colorbin_pkg::PIX_W-1 -: colorbin_pkg::FIELD_W];
	assign val = i_value[colorbin_pkg::PIX_W-1 -: colorbin_pkg::FIELD_W];

	// first matching rule wins
	always_comb begin
		if (sat < colorbin_pkg::SAT_WHITE_MAX) begin
			cls = colorbin_pkg::WHITE;
		end else if (val <= colorbin_pkg::VALUE_MIN || sat <= colorbin_pkg::SAT_MIN) begin
			cls = colorbin_pkg::OTHER;
		end else if (hue >= colorbin_pkg::HUE_RED_LO || hue < colorbin_pkg::HUE_ORANGE_LO) begin
			// red wraps through 0 degrees
			cls = colorbin_pkg::RED;
		end else if (hue < colorbin_pkg::HUE_YELLOW_LO) begin
			cls = (sat > colorbin_pkg::ORANGE_SAT_MIN) ? colorbin_pkg::ORANGE
			                                           : colorbin_pkg::OTHER;
		end else if (hue < colorbin_pkg::HUE_GREEN_LO) begin
			cls = colorbin_pkg::YELLOW;
		end else if (hue < colorbin_pkg::HUE_BLUE_LO) begin
			cls = colorbin_pkg::GREEN;
		end else if (hue < colorbin_pkg::HUE_BLUE_HI) begin
			cls = colorbin_pkg::BLUE;
		end else begin
			cls = colorbin_pkg::OTHER;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			o_tag.tag_class <= cls;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cell_histogram.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cell histogram: per-cell, per-class pixel counters, snapshot and
// clear on the last pixel of each frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cell_histogram (
	input  wire           i_clk,
	input  wire           i_rstn,
	pixel_tag_if.sink     i_tag,
	output colorbin_pkg::count_t o_counts [colorbin_pkg::NUM_CELLS][colorbin_pkg::NUM_CLASSES],
	output logic          o_frame_end
);

	colorbin_pkg::count_t counts [colorbin_pkg::NUM_CELLS][colorbin_pkg::NUM_CLASSES];
	logic [2:0]           cls_idx;
	logic                 last_tag;

	// class codes 1..7 map to counter slots 0..6
	assign cls_idx  = 3'(i_tag.tag_class) - 3'd1;
	assign last_tag = i_tag.tag_valid & i_tag.tag_last;

	always_ff @(posedge i_clk) begin
		if (!i_rstn || last_tag) begin
			for (int c = 0; c < colorbin_pkg::NUM_CELLS; c++) begin
				for (int k = 0; k < colorbin_pkg::NUM_CLASSES; k++) begin
					counts[c][k] <= '0;
				end
			end
		end else if (i_tag.tag_valid && i_tag.tag_hit) begin
			counts[i_tag.tag_cell][cls_idx] <= counts[i_tag.tag_cell][cls_idx] + 1'b1;
		end
	end

	// final counts held for the decision while the live set restarts
	always_ff @(posedge i_clk) begin
		if (last_tag) begin
			o_counts <= counts;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			o_frame_end <= 1'b0;
		end else begin
			o_frame_end <= last_tag;
		end
	end

endmodule

`default_nettype wire

// File: rtl/dominant_pick.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dominant pick: per-cell argmax over the class counts, registered
// into the face word at the end of each frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module dominant_pick (
	input  wire                  i_clk,
	input  wire                  i_rstn,
	input  colorbin_pkg::count_t i_counts [colorbin_pkg::NUM_CELLS][colorbin_pkg::NUM_CLASSES],
	input  wire                  i_frame_end,
	output colorbin_pkg::face_t  o_face
);

	colorbin_pkg::color_e pick [colorbin_pkg::NUM_CELLS];

	// strict compare keeps the lowest code on a tie
	function automatic colorbin_pkg::color_e argmax(
		input colorbin_pkg::count_t cnt [colorbin_pkg::NUM_CLASSES]
	);
		logic [2:0] best;
		best = 3'd0;
		for (int k = 1; k < colorbin_pkg::NUM_CLASSES; k++) begin
			if (cnt[k] > cnt[best]) begin
				best = 3'(k);
			end
		end
		return colorbin_pkg::color_e'(best + 3'd1);
	endfunction

	always_comb begin
		for (int c = 0; c < colorbin_pkg::NUM_CELLS; c++) begin
			pick[c] = argmax(i_counts[c]);
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			for (int c = 0; c < colorbin_pkg::NUM_CELLS; c++) begin
				o_face[c] <= colorbin_pkg::NONE;
			end
		end else if (i_frame_end) begin
			for (int c = 0; c < colorbin_pkg::NUM_CELLS; c++) begin
				o_face[c] <= pick[c];
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/colorbin_top.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour binner top: classifies an HSV pixel stream and reports the
// dominant colour of each cell of a 3x3 face once per frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module colorbin_top #(
	parameter int FRAME_W    = 480,
	parameter int FRAME_H    = 480,
	parameter int CELL_SIZE  = 156,
	// the last pixel (FRAME_W-1, FRAME_H-1) must fall outside every cell
	parameter int CELL_PITCH = 160
) (
	input  wire                            i_clk,
	input  wire                            i_rstn,
	input  wire [colorbin_pkg::PIX_W-1:0] i_hue,
	input  wire [colorbin_pkg::PIX_W-1:0] i_sat,
	input  wire [colorbin_pkg::PIX_W-1:0] i_value,
	input  wire                            i_valid,
	output colorbin_pkg::face_t            o_face
);

	pixel_tag_if tag_if ();

	colorbin_pkg::count_t counts [colorbin_pkg::NUM_CELLS][colorbin_pkg::NUM_CLASSES];
	logic                 frame_end;

	grid_locator #(
		.FRAME_W    (FRAME_W),
		.FRAME_H    (FRAME_H),
		.CELL_SIZE  (CELL_SIZE),
		.CELL_PITCH (CELL_PITCH)
	) u_locator (
		.i_clk   (i_clk),
		.i_rstn  (i_rstn),
		.i_valid (i_valid),
		.o_tag   (tag_if.locator)
	);

	hsv_classify u_classify (
		.i_clk   (i_clk),
		.i_hue   (i_hue),
		.i_sat   (i_sat),
		.i_value (i_value),
		.i_valid (i_valid),
		.o_tag   (tag_if.classifier)
	);

	cell_histogram u_histogram (
		.i_clk       (i_clk),
		.i_rstn      (i_rstn),
		.i_tag       (tag_if.sink),
		.o_counts    (counts),
		.o_frame_end (frame_end)
	);

	dominant_pick u_pick (
		.i_clk       (i_clk),
		.i_rstn      (i_rstn),
		.i_counts    (counts),
		.i_frame_end (frame_end),
		.o_face      (o_face)
	);

endmodule

`default_nettype wire

// File: dv/colorbin_tb.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour binner testbench: frame generator, reference face model,
// per-cell face checks and a watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module colorbin_tb;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DLY  = 10;
	localparam int SAMPLE_DLY = 50;
	localparam int FRAME_W    = 480;
	localparam int FRAME_H    = 480;
	localparam int CELL_SIZE  = 156;
	localparam int CELL_PITCH = 160;
	localparam int FRAME_PIX  = FRAME_W * FRAME_H;
	localparam int NUM_FRAMES = 5;
	localparam int WATCHDOG_NS = 2 * NUM_FRAMES * FRAME_PIX * CLK_PERIOD;

	localparam logic [2:0] C_RED    = 3'd1;
	localparam logic [2:0] C_ORANGE = 3'd2;
	localparam logic [2:0] C_YELLOW = 3'd3;
	localparam logic [2:0] C_GREEN  = 3'd4;
	localparam logic [2:0] C_BLUE   = 3'd5;
	localparam logic [2:0] C_WHITE  = 3'd6;
	localparam logic [2:0] C_OTHER  = 3'd7;

	localparam int SAT_WHITE_MAX  = 10;
	localparam int SAT_MIN        = 50;
	localparam int ORANGE_SAT_MIN = 90;
	localparam int VALUE_MIN      = 10;
	localparam int HUE_RED_LO     = 325;
	localparam int HUE_ORANGE_LO  = 10;
	localparam int HUE_YELLOW_LO  = 40;
	localparam int HUE_GREEN_LO   = 75;
	localparam int HUE_BLUE_LO    = 140;
	localparam int HUE_BLUE_HI    = 280;

	logic        i_clk;
	logic        i_rstn;
	logic        i_valid;
	logic [15:0] i_hue;
	logic [15:0] i_sat;
	logic [15:0] i_value;
	logic [26:0] o_face;

	logic [15:0] hue_mem [FRAME_PIX];
	logic [15:0] sat_mem [FRAME_PIX];
	logic [15:0] val_mem [FRAME_PIX];
	logic [26:0] exp_q [$];
	int          frames_checked;
	int          hue_edges [12] = '{9, 10, 39, 40, 74, 75, 139, 140, 279, 280, 324, 325};
	int          sat_edges [9]  = '{9, 10, 11, 49, 50, 51, 89, 90, 91};
	event        last_accepted;

	colorbin_top uut (
		.i_clk   (i_clk),
		.i_rstn  (i_rstn),
		.i_hue   (i_hue),
		.i_sat   (i_sat),
		.i_value (i_value),
		.i_valid (i_valid),
		.o_face  (o_face)
	);

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s expected 0x%h actual 0x%h", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic check_face(input logic [26:0] expected);
		for (int c = 0; c < 9; c++) begin
			check_value($sformatf("o_face[%0d]", c), expected[3*c +: 3], o_face[3*c +: 3]);
		end
	endtask

	// index of the cell window holding pos, -1 in a gap or border
	function automatic int window(input int pos);
		for (int n = 0; n < 3; n++) begin
			if (pos >= n * CELL_PITCH && pos < n * CELL_PITCH + CELL_SIZE) begin
				return n;
			end
		end
		return -1;
	endfunction

	function automatic int classify(input logic [15:0] h_in, s_in, v_in);
		int h;
		int s;
		int v;
		int cls;
		h = h_in[15:6];
		s = s_in[15:6];
		v = v_in[15:6];
		if (s < SAT_WHITE_MAX) begin
			cls = C_WHITE;
		end else if (v <= VALUE_MIN || s <= SAT_MIN) begin
			cls = C_OTHER;
		end else if (h >= HUE_RED_LO || h < HUE_ORANGE_LO) begin
			cls = C_RED;
		end else if (h < HUE_YELLOW_LO) begin
			cls = (s > ORANGE_SAT_MIN) ? C_ORANGE : C_OTHER;
		end else if (h < HUE_GREEN_LO) begin
			cls = C_YELLOW;
		end else if (h < HUE_BLUE_LO) begin
			cls = C_GREEN;
		end else if (h < HUE_BLUE_HI) begin
			cls = C_BLUE;
		end else begin
			cls = C_OTHER;
		end
		return cls;
	endfunction

	// expected face of the frame now held in the pixel arrays
	function automatic logic [26:0] ref_face();
		int          cnt [9][7];
		int          row;
		int          col;
		int          cls;
		int          best;
		logic [26:0] face;
		for (int c = 0; c < 9; c++) begin
			for (int k = 0; k < 7; k++) begin
				cnt[c][k] = 0;
			end
		end
		for (int y = 0; y < FRAME_H; y++) begin
			row = window(y);
			for (int x = 0; x < FRAME_W; x++) begin
				col = window(x);
				if (row >= 0 && col >= 0) begin
					cls = classify(hue_mem[y*FRAME_W+x], sat_mem[y*FRAME_W+x],
						val_mem[y*FRAME_W+x]);
					cnt[row*3+col][cls-1] = cnt[row*3+col][cls-1] + 1;
				end
			end
		end
		face = '0;
		for (int c = 0; c < 9; c++) begin
			best = 0;
			for (int k = 1; k < 7; k++) begin
				if (cnt[c][k] > cnt[c][best]) begin
					best = k;
				end
			end
			face[3*c +: 3] = 3'(best + 1);
		end
		return face;
	endfunction

	// {hue, sat, value} of one clean pixel of a class, random fraction bits
	function automatic logic [47:0] pixel_of(input logic [2:0] code);
		logic [9:0]  h;
		logic [9:0]  s;
		logic [9:0]  v;
		logic [17:0] frac;
		h = 10'd0;
		s = 10'd200;
		v = 10'd200;
		frac = 18'($urandom);
		case (code)
			C_RED:    h = 10'd350;
			C_ORANGE: begin
				h = 10'd25;
				s = 10'd150;
			end
			C_YELLOW: h = 10'd60;
			C_GREEN:  h = 10'd100;
			C_BLUE:   h = 10'd200;
			C_WHITE:  begin
				s = 10'd5;
				v = 10'd250;
			end
			// hue gap between blue and red
			default:  h = 10'd300;
		endcase
		return {h, frac[17:12], s, frac[11:6], v, frac[5:0]};
	endfunction

	task automatic fill_pure(input logic [26:0] codes);
		int          row;
		int          col;
		logic [2:0]  code;
		logic [47:0] px;
		for (int y = 0; y < FRAME_H; y++) begin
			row = window(y);
			for (int x = 0; x < FRAME_W; x++) begin
				col = window(x);
				if (row >= 0 && col >= 0) begin
					code = codes[3*(row*3+col) +: 3];
				end else begin
					// border cycles through every class
					code = 3'(1 + (x + y) % 7);
				end
				px = pixel_of(code);
				hue_mem[y*FRAME_W+x] = px[47:32];
				sat_mem[y*FRAME_W+x] = px[31:16];
				val_mem[y*FRAME_W+x] = px[15:0];
			end
		end
	endtask

	// random pixels, biased towards the threshold edges
	task automatic fill_random();
		logic [9:0]  h;
		logic [9:0]  s;
		logic [9:0]  v;
		logic [17:0] frac;
		for (int i = 0; i < FRAME_PIX; i++) begin
			frac = 18'($urandom);
			h = ($urandom % 4 == 0) ? 10'(hue_edges[$urandom % 12]) : 10'($urandom % 360);
			s = ($urandom % 3 == 0) ? 10'(sat_edges[$urandom % 9]) : 10'($urandom % 256);
			v = ($urandom % 8 == 0) ? 10'(9 + $urandom % 3) : 10'($urandom % 256);
			hue_mem[i] = {h, frac[17:12]};
			sat_mem[i] = {s, frac[11:6]};
			val_mem[i] = {v, frac[5:0]};
		end
	endtask

	task automatic send_frame(input bit gaps);
		int idx;
		idx = 0;
		while (idx < FRAME_PIX) begin
			if (gaps && $urandom % 4 == 0) begin
				// idle cycle with junk on the pixel bus
				i_valid = 1'b0;
				i_hue   = 16'($urandom);
				i_sat   = 16'($urandom);
				i_value = 16'($urandom);
			end else begin
				i_valid = 1'b1;
				i_hue   = hue_mem[idx];
				i_sat   = sat_mem[idx];
				i_value = val_mem[idx];
				idx++;
			end
			@(posedge i_clk);
			#DRIVE_DLY;
		end
		-> last_accepted;
		i_valid = 1'b0;
	endtask

	initial begin : compare
		logic [26:0] prev_face;
		logic [26:0] expected;
		prev_face = '0;
		forever begin
			@(last_accepted);
			@(posedge i_clk);
			#SAMPLE_DLY;
			// old face still held one edge after the last pixel
			check_face(prev_face);
			@(posedge i_clk);
			#SAMPLE_DLY;
			expected = exp_q.pop_front();
			check_face(expected);
			prev_face = expected;
			frames_checked++;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout: the frames did not complete in the expected time");
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin : stimulus
		int          seed;
		logic [26:0] codes;
		seed = 14;
		void'($urandom(seed));
		frames_checked = 0;
		i_rstn  = 1'b0;
		i_valid = 1'b0;
		i_hue   = '0;
		i_sat   = '0;
		i_value = '0;
		repeat (5) @(posedge i_clk);
		#DRIVE_DLY;
		i_rstn = 1'b1;
		check_face(27'd0);

		codes = {C_GREEN, C_RED, C_OTHER, C_WHITE, C_BLUE, C_GREEN, C_YELLOW, C_ORANGE, C_RED};
		fill_pure(codes);
		exp_q.push_back(codes);
		send_frame(1'b0);

		fill_random();
		exp_q.push_back(ref_face());
		send_frame(1'b0);

		// same pixels with gaps, then without
		fill_random();
		exp_q.push_back(ref_face());
		send_frame(1'b1);
		exp_q.push_back(ref_face());
		send_frame(1'b0);

		codes = {C_RED, C_ORANGE, C_YELLOW, C_GREEN, C_BLUE, C_WHITE, C_OTHER, C_BLUE, C_WHITE};
		fill_pure(codes);
		exp_q.push_back(codes);
		send_frame(1'b0);

		wait (frames_checked == NUM_FRAMES);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: colorbin_top.f
rtl/colorbin_pkg.sv
rtl/pixel_tag_if.sv
rtl/grid_locator.sv
rtl/hsv_classify.sv
rtl/cell_histogram.sv
rtl/dominant_pick.sv
rtl/colorbin_top.sv
dv/colorbin_tb.sv
